// ==== gat_defines.svh ====
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// Signed width of one weight and one feature element.
`define GAT_DATA_W 8

// Matrix shape.
// The row count is also the feature vector length.
`define GAT_W_ROWS 8

// The column count is also the number of lanes.
`define GAT_W_COLS 4

// Index widths into the matrix.
`define GAT_ROW_W 3
`define GAT_COL_W 2

// Linear store holds GAT_W_ROWS * GAT_W_COLS words.
`define GAT_STORE_ADDR_W 5

// Product width plus growth over GAT_W_ROWS additions.
// Wide enough that a full dot product never overflows.
`define GAT_ACC_W 19

`endif

// ==== gat_pkg.sv ====
`default_nettype none

`include "gat_defines.svh"

package gat_pkg;

  // Weight write from the loader into the lane banks.
  // Every lane sees it and only the matching column writes.
  typedef struct packed {
    logic                   ena;   // Write strobe.
    logic [`GAT_COL_W-1:0]  col;   // Target lane.
    logic [`GAT_ROW_W-1:0]  row;   // Row slot in the bank.
    logic [`GAT_DATA_W-1:0] data;  // Signed weight.
  } bank_wr_t;

  // One feature element broadcast to all lanes.
  typedef struct packed {
    logic                   valid;
    logic                   last;  // Final element of a vector.
    logic [`GAT_ROW_W-1:0]  row;   // Element index in the vector.
    logic [`GAT_DATA_W-1:0] data;  // Signed feature value.
  } feat_beat_t;

  // Finished dot product from one lane.
  typedef struct packed {
    logic                   done;  // One-cycle pulse.
    logic [`GAT_ACC_W-1:0]  sum;   // Signed, two's complement.
  } lane_sum_t;

endpackage

`default_nettype wire

// ==== weight_store.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gat_defines.svh"

// Host-written weight matrix, row-major, one word per address.
module weight_store (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          wr_en,
  input  wire [`GAT_STORE_ADDR_W-1:0]  wr_addr,
  input  wire [`GAT_DATA_W-1:0]        wr_data,
  input  wire [`GAT_STORE_ADDR_W-1:0]  rd_addr,
  output logic [`GAT_DATA_W-1:0]       rd_data
);

  localparam int unsigned DEPTH = `GAT_W_ROWS * `GAT_W_COLS;

  logic [`GAT_DATA_W-1:0] mem [DEPTH];

  // Synchronous write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data returns one cycle after the address.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== w_loader.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gat_defines.svh"

module w_loader (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          load_start,
  output logic [`GAT_STORE_ADDR_W-1:0] store_addr,
  input  wire [`GAT_DATA_W-1:0]        store_data,
  output gat_pkg::bank_wr_t            bank_wr,
  output logic                         w_ready,
  input  wire                          feat_valid,
  input  wire [`GAT_DATA_W-1:0]        feat_data,
  input  wire                          feat_last,
  output gat_pkg::feat_beat_t          feat_beat
);

  import gat_pkg::*;

  localparam int unsigned LAST_ADDR = `GAT_W_ROWS * `GAT_W_COLS - 1;
  localparam int unsigned LAST_ROW  = `GAT_W_ROWS - 1;

  logic                          load_active;  // Addresses still being issued.
  logic [`GAT_STORE_ADDR_W-1:0]  load_cnt;
  logic                          rd_pending;   // Store data valid this cycle.
  logic [`GAT_STORE_ADDR_W-1:0]  rd_addr_q;    // Address that produced store_data.
  logic [`GAT_ROW_W-1:0]         feat_row;
  logic                          feat_accept;
  logic                          row_is_last;
  logic                          beat_valid;
  logic                          beat_last;
  logic [`GAT_ROW_W-1:0]         beat_row;
  logic [`GAT_DATA_W-1:0]        beat_data;

  assign store_addr = load_cnt;

  // Walk the whole store once per load command.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_active <= 1'b0;
      load_cnt    <= '0;
      rd_pending  <= 1'b0;
    end else if (load_start) begin
      load_active <= 1'b1;
      load_cnt    <= '0;
      rd_pending  <= 1'b0;   // Drop any read still in flight.
    end else begin
      rd_pending <= load_active;
      if (load_active) begin
        load_cnt <= load_cnt + 1'b1;
        if (load_cnt == `GAT_STORE_ADDR_W'(LAST_ADDR)) begin
          load_active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_addr_q <= load_cnt;
  end

  // Row-major address splits into row (upper bits) and column (lower bits).
  assign bank_wr = '{ena:  rd_pending,
                     col:  rd_addr_q[`GAT_COL_W-1:0],
                     row:  rd_addr_q[`GAT_COL_W +: `GAT_ROW_W],
                     data: store_data};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_ready <= 1'b0;
    end else if (load_start) begin
      w_ready <= 1'b0;
    end else if (rd_pending && rd_addr_q == `GAT_STORE_ADDR_W'(LAST_ADDR)) begin
      w_ready <= 1'b1;       // Last bank write lands this cycle.
    end
  end

  // Features only count once the banks are complete.
  assign feat_accept = feat_valid && w_ready;
  assign row_is_last = (feat_row == `GAT_ROW_W'(LAST_ROW));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_row   <= '0;
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= feat_accept;
      beat_last  <= feat_accept && row_is_last;
      if (load_start) begin
        feat_row <= '0;
      end else if (feat_accept) begin
        feat_row <= row_is_last ? '0 : feat_row + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (feat_accept) begin
      beat_row  <= feat_row;
      beat_data <= feat_data;
    end
  end

  assign feat_beat = '{valid: beat_valid, last: beat_last, row: beat_row, data: beat_data};

  // Host framing must match the internal row count.
  a_last_matches_row: assert property (
    @(posedge clk) disable iff (!rst_n)
    feat_accept |-> (feat_last == row_is_last)
  ) else $error("w_loader: feat_last disagrees with row %0d", feat_row);

  // A reload would strand the lane accumulators mid-vector.
  a_no_reload_mid_vector: assert property (
    @(posedge clk) disable iff (!rst_n)
    load_start |-> (feat_row == '0)
  ) else $error("w_loader: load_start during a partial feature vector");

endmodule

`default_nettype wire

// ==== weight_column_lane.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gat_defines.svh"

// One output column. Holds its weight column and forms the dot product.
module weight_column_lane #(
  parameter int unsigned LANE_IDX = 0
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire gat_pkg::bank_wr_t   bank_wr,
  input  wire gat_pkg::feat_beat_t feat_beat,
  output gat_pkg::lane_sum_t    lane_sum
);

  import gat_pkg::*;

  localparam int unsigned PROD_W = 2 * `GAT_DATA_W;

  logic        [`GAT_DATA_W-1:0] bank [`GAT_W_ROWS];
  logic signed [`GAT_DATA_W-1:0] weight;
  logic signed [PROD_W-1:0]      prod;
  logic signed [`GAT_ACC_W-1:0]  acc;
  logic signed [`GAT_ACC_W-1:0]  acc_next;
  logic                          bank_hit;
  logic                          done_q;
  logic        [`GAT_ACC_W-1:0]  sum_q;

  // Only writes addressed to this column land here.
  assign bank_hit = bank_wr.ena && (bank_wr.col == `GAT_COL_W'(LANE_IDX));

  always_ff @(posedge clk) begin
    if (bank_hit) begin
      bank[bank_wr.row] <= bank_wr.data;
    end
  end

  assign weight   = bank[feat_beat.row];                 // Async bank read.
  assign prod     = weight * $signed(feat_beat.data);
  assign acc_next = acc + `GAT_ACC_W'(prod);             // Sign-extended add.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= feat_beat.valid && feat_beat.last;
      if (feat_beat.valid) begin
        // Restart from zero so the next vector starts clean.
        acc <= feat_beat.last ? '0 : acc_next;
      end
    end
  end

  // Final sum includes the last element's product.
  always_ff @(posedge clk) begin
    if (feat_beat.valid && feat_beat.last) begin
      sum_q <= acc_next;
    end
  end

  assign lane_sum = '{done: done_q, sum: sum_q};

endmodule

`default_nettype wire

// ==== lane_collector.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gat_defines.svh"

module lane_collector (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire gat_pkg::lane_sum_t [`GAT_W_COLS-1:0] lane_sums,
  output logic                                    res_valid,
  output logic [`GAT_COL_W-1:0]                   res_col,
  output logic [`GAT_ACC_W-1:0]                   res_sum
);

  import gat_pkg::*;

  localparam int unsigned LAST_COL = `GAT_W_COLS - 1;

  logic [`GAT_W_COLS-1:0] done_vec;
  logic [`GAT_ACC_W-1:0]  sum_q [`GAT_W_COLS];
  logic                   emit_busy;
  logic [`GAT_COL_W-1:0]  emit_col;

  always_comb begin
    for (int i = 0; i < `GAT_W_COLS; i++) begin
      done_vec[i] = lane_sums[i].done;
    end
  end

  // Snapshot every lane at once; lane 0 stands for all.
  always_ff @(posedge clk) begin
    if (done_vec[0]) begin
      for (int i = 0; i < `GAT_W_COLS; i++) begin
        sum_q[i] <= lane_sums[i].sum;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      emit_busy <= 1'b0;
      emit_col  <= '0;
    end else if (done_vec[0]) begin
      emit_busy <= 1'b1;
      emit_col  <= '0;
    end else if (emit_busy) begin
      emit_col <= emit_col + 1'b1;
      if (emit_col == `GAT_COL_W'(LAST_COL)) begin
        emit_busy <= 1'b0;   // Last column out.
      end
    end
  end

  assign res_valid = emit_busy;
  assign res_col   = emit_col;
  assign res_sum   = sum_q[emit_col];

  // Lanes share one beat stream so they must finish together.
  a_done_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|done_vec) |-> (&done_vec)
  ) else $error("lane_collector: lanes finished out of step %b", done_vec);

  // A vector is at least as long as one emission group.
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    emit_busy |-> !done_vec[0]
  ) else $error("lane_collector: new result while column %0d still pending", emit_col);

endmodule

`default_nettype wire

// ==== gat_linear_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gat_defines.svh"

// Dense projection of node features through a GAT weight matrix.
module gat_linear_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          wr_en,
  input  wire [`GAT_STORE_ADDR_W-1:0]  wr_addr,
  input  wire [`GAT_DATA_W-1:0]        wr_data,
  input  wire                          load_start,
  output logic                         w_ready,
  input  wire                          feat_valid,
  input  wire [`GAT_DATA_W-1:0]        feat_data,
  input  wire                          feat_last,
  output logic                         res_valid,
  output logic [`GAT_COL_W-1:0]        res_col,
  output logic [`GAT_ACC_W-1:0]        res_sum
);

  import gat_pkg::*;

  logic [`GAT_STORE_ADDR_W-1:0]    store_addr;
  logic [`GAT_DATA_W-1:0]          store_data;
  bank_wr_t                        bank_wr;
  feat_beat_t                      feat_beat;
  lane_sum_t [`GAT_W_COLS-1:0]     lane_sums;

  weight_store u_weight_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (store_addr),
    .rd_data (store_data)
  );

  w_loader u_w_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_start (load_start),
    .store_addr (store_addr),
    .store_data (store_data),
    .bank_wr    (bank_wr),
    .w_ready    (w_ready),
    .feat_valid (feat_valid),
    .feat_data  (feat_data),
    .feat_last  (feat_last),
    .feat_beat  (feat_beat)
  );

  // One lane per output column.
  for (genvar g = 0; g < `GAT_W_COLS; g++) begin : g_lane
    weight_column_lane #(
      .LANE_IDX (g)
    ) u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .bank_wr   (bank_wr),
      .feat_beat (feat_beat),
      .lane_sum  (lane_sums[g])
    );
  end

  lane_collector u_lane_collector (
    .clk       (clk),
    .rst_n     (rst_n),
    .lane_sums (lane_sums),
    .res_valid (res_valid),
    .res_col   (res_col),
    .res_sum   (res_sum)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

// Free-running clock and a power-on reset for the testbench.
module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;   // Released on a clock edge.
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb_gat_linear.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "gat_defines.svh"

module tb_gat_linear;

  localparam int ROWS           = `GAT_W_ROWS;
  localparam int COLS           = `GAT_W_COLS;
  localparam int LOAD_LAT       = 34;   // load_start cycle to w_ready high.
  localparam int RES_LAT        = 3;    // Last element to column 0 out.
  localparam int RESET_TIMEOUT  = 40;
  localparam int LOAD_TIMEOUT   = 100;
  localparam int DRAIN_TIMEOUT  = 100;
  localparam int MODE_RANDOM    = 0;
  localparam int MODE_MAX       = 1;
  localparam int MODE_MIN       = 2;
  localparam int MAX_VAL        = (1 << (`GAT_DATA_W - 1)) - 1;
  localparam int MIN_VAL        = -(1 << (`GAT_DATA_W - 1));

  // One expected output word.
  typedef struct packed {
    int                    cycle;
    logic [`GAT_COL_W-1:0] col;
    int                    sum;
  } exp_res_t;

  logic                         clk;
  logic                         rst_n;
  logic                         wr_en;
  logic [`GAT_STORE_ADDR_W-1:0] wr_addr;
  logic [`GAT_DATA_W-1:0]       wr_data;
  logic                         load_start;
  logic                         w_ready;
  logic                         feat_valid;
  logic [`GAT_DATA_W-1:0]       feat_data;
  logic                         feat_last;
  logic                         res_valid;
  logic [`GAT_COL_W-1:0]        res_col;
  logic [`GAT_ACC_W-1:0]        res_sum;

  int       w_model [ROWS][COLS];   // Mirror of the host writes.
  int       feat_vec [ROWS];
  exp_res_t exp_q [$];
  int       cycle_cnt   = 0;
  int       err_cnt     = 0;
  int       timeout_cnt = 0;
  int       result_cnt  = 0;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_linear_top u_gat_linear_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .load_start (load_start),
    .w_ready    (w_ready),
    .feat_valid (feat_valid),
    .feat_data  (feat_data),
    .feat_last  (feat_last),
    .res_valid  (res_valid),
    .res_col    (res_col),
    .res_sum    (res_sum)
  );

  always @(posedge clk) cycle_cnt++;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic int value_for_mode(input int mode);
    logic [`GAT_DATA_W-1:0] raw;
    raw = `GAT_DATA_W'($urandom);
    case (mode)
      MODE_MAX: return MAX_VAL;
      MODE_MIN: return MIN_VAL;
      default:  return int'($signed(raw));
    endcase
  endfunction

  function automatic int dot_product(input int col);
    int acc;
    acc = 0;
    for (int r = 0; r < ROWS; r++) begin
      acc += feat_vec[r] * w_model[r][col];
    end
    return acc;
  endfunction

  task automatic write_matrix(input int mode);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        w_model[r][c] = value_for_mode(mode);
        wr_en   = 1'b1;
        wr_addr = `GAT_STORE_ADDR_W'(r * COLS + c);   // Row-major.
        wr_data = `GAT_DATA_W'(w_model[r][c]);
        next_cycle();
      end
    end
    wr_en = 1'b0;
  endtask

  // Pulse load_start and time w_ready. Optional strobes go out while not ready.
  task automatic load_weights(input int drop_cnt);
    int wait_cyc;
    load_start = 1'b1;
    next_cycle();
    load_start = 1'b0;
    wait_cyc   = 1;
    assert (!w_ready) else begin
      err_cnt++;
      $display("FAILED at %0t: w_ready still high after load_start", $time);
    end
    while (!w_ready && wait_cyc < LOAD_TIMEOUT) begin
      feat_valid = (wait_cyc <= drop_cnt);
      feat_data  = `GAT_DATA_W'($urandom);
      feat_last  = (wait_cyc == drop_cnt);
      next_cycle();
      wait_cyc++;
    end
    feat_valid = 1'b0;
    feat_last  = 1'b0;
    if (!w_ready) begin
      timeout_cnt++;
      $display("Timeout: w_ready did not rise within %0d cycles of load_start", LOAD_TIMEOUT);
    end else begin
      assert (wait_cyc == LOAD_LAT) else begin
        err_cnt++;
        $display("FAILED at %0t: w_ready after %0d cycles, expected %0d",
                 $time, wait_cyc, LOAD_LAT);
      end
    end
  endtask

  task automatic send_vector(input int elem_gap_max, input int mode);
    int       last_cyc;
    exp_res_t e;
    last_cyc = 0;
    for (int r = 0; r < ROWS; r++) begin
      feat_vec[r] = value_for_mode(mode);
      assert (w_ready) else begin
        err_cnt++;
        $display("Feature vector started at %0t while w_ready is low", $time);
      end
      feat_valid = 1'b1;
      feat_data  = `GAT_DATA_W'(feat_vec[r]);
      feat_last  = (r == ROWS - 1);
      if (r == ROWS - 1) begin
        last_cyc = cycle_cnt;
      end
      next_cycle();
      feat_valid = 1'b0;
      feat_last  = 1'b0;
      if (r < ROWS - 1) begin
        repeat ($urandom_range(elem_gap_max, 0)) next_cycle();
      end
    end
    for (int c = 0; c < COLS; c++) begin
      e.cycle = last_cyc + RES_LAT + c;   // One column per cycle.
      e.col   = `GAT_COL_W'(c);
      e.sum   = dot_product(c);
      exp_q.push_back(e);
    end
  endtask

  task automatic drain_results();
    int wait_cyc;
    wait_cyc = 0;
    while ((exp_q.size() > 0 || res_valid) && wait_cyc < DRAIN_TIMEOUT) begin
      next_cycle();
      wait_cyc++;
    end
    if (exp_q.size() > 0) begin
      timeout_cnt++;
      $display("Timeout: %0d expected results never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  // Result monitor, sampled mid-cycle.
  always @(negedge clk) begin
    exp_res_t e;
    int       got;
    if (rst_n && res_valid) begin
      got = int'($signed(res_sum));
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Unexpected result for column %0d at %0t with nothing outstanding",
                 res_col, $time);
      end else begin
        e = exp_q.pop_front();
        result_cnt++;
        assert (res_col == e.col) else begin
          err_cnt++;
          $display("FAILED at %0t: res_col %0d, expected %0d", $time, res_col, e.col);
        end
        assert (got == e.sum) else begin
          err_cnt++;
          $display("FAILED at %0t: column %0d sum %0d, expected %0d",
                   $time, e.col, got, e.sum);
        end
        assert (cycle_cnt == e.cycle) else begin
          err_cnt++;
          $display("FAILED at %0t: column %0d in cycle %0d, expected cycle %0d",
                   $time, e.col, cycle_cnt, e.cycle);
        end
      end
    end
  end

  initial begin
    int wait_cyc;
    void'($urandom(32'h8aff_7629));
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    load_start = 1'b0;
    feat_valid = 1'b0;
    feat_data  = '0;
    feat_last  = 1'b0;

    next_cycle();   // Let reset settle.
    wait_cyc = 0;
    while (!rst_n && wait_cyc < RESET_TIMEOUT) begin
      assert (!w_ready && !res_valid) else begin
        err_cnt++;
        $display("FAILED at %0t: outputs active during reset", $time);
      end
      next_cycle();
      wait_cyc++;
    end
    if (!rst_n) begin
      timeout_cnt++;
      $display("Timeout: reset was never released");
    end

    // Idle after reset. Strobes before any load are dropped.
    for (int i = 0; i < 10; i++) begin
      feat_valid = (i < 5);
      feat_data  = `GAT_DATA_W'($urandom);
      next_cycle();
      assert (!w_ready && !res_valid) else begin
        err_cnt++;
        $display("FAILED at %0t: w_ready or res_valid high before any load", $time);
      end
    end
    feat_valid = 1'b0;

    // First matrix and random vectors.
    write_matrix(MODE_RANDOM);
    load_weights(0);
    for (int v = 0; v < 4; v++) begin
      send_vector(2, MODE_RANDOM);
      repeat ($urandom_range(3, 0)) next_cycle();
    end
    drain_results();

    // Strobes during the load are ignored.
    write_matrix(MODE_RANDOM);
    load_weights(12);
    send_vector(0, MODE_RANDOM);
    drain_results();

    // Reload and confirm only the new weights count.
    write_matrix(MODE_RANDOM);
    load_weights(0);
    send_vector(1, MODE_RANDOM);
    send_vector(0, MODE_RANDOM);
    drain_results();

    // Back-to-back vectors with short gaps.
    for (int v = 0; v < 12; v++) begin
      send_vector(0, MODE_RANDOM);
      repeat ($urandom_range(3, 0)) next_cycle();
    end
    drain_results();

    // Extreme values at both ends of the range.
    write_matrix(MODE_MAX);
    load_weights(0);
    send_vector(0, MODE_MAX);
    send_vector(0, MODE_MIN);
    drain_results();
    write_matrix(MODE_MIN);
    load_weights(0);
    send_vector(0, MODE_MIN);
    send_vector(0, MODE_MAX);
    drain_results();

    repeat (5) next_cycle();
    $display("Results checked: %0d, errors: %0d, timeouts: %0d",
             result_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
gat_pkg.sv
weight_store.sv
w_loader.sv
weight_column_lane.sv
lane_collector.sv
gat_linear_top.sv
tb_clock_gen.sv
tb_gat_linear.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_gat_linear -f flist.f -o sim_gat
	./obj_dir/sim_gat > $(LOG) 2>&1 || echo "Regression failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Regression failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
